/* cpu_top.f */
rtl/cpu_pkg.sv
rtl/regs.sv
rtl/fetch.sv
rtl/decode.sv
rtl/alu.sv
rtl/memory.sv
rtl/cpu.sv
rtl/cpu_top.sv
sim/tb_cpu_top.sv

/* run.sh */
#!/bin/sh
# build and run the cpu_top testbench with Verilator
cd "$(dirname "$0")" \
    && verilator --binary --timing --top-module tb_cpu_top -f cpu_top.f -o sim_cpu_top \
    && ./obj_dir/sim_cpu_top \
    || { echo "simulation failed"; exit 1; }
echo "simulation passed"

/* sim/tb_cpu_top.sv */
`timescale 1ns/1ps

module tb_cpu_top;
    import cpu_pkg::*;

    localparam int reset_cycles = 16;
    localparam int retire_limit = 50;
    localparam int max_retires  = 500;

    logic              clk;
    logic              rstn;
    logic              imem_we;
    logic [7:0]        imem_addr;
    logic [word_w-1:0] imem_wdata;
    logic [word_w-1:0] pc;
    logic              retire_valid;
    logic              retire_we;
    logic [reg_aw-1:0] retire_rd;
    logic [word_w-1:0] retire_data;
    logic              halted;

    // program image and reference machine state
    logic [31:0] prog [256];
    int          prog_len;
    logic [31:0] model_regs [16];
    logic [31:0] model_dmem [256];
    logic [31:0] model_pc;
    integer      seed;

    cpu_top i_cpu_top (
        .clk          (clk),
        .rstn         (rstn),
        .imem_we      (imem_we),
        .imem_addr    (imem_addr),
        .imem_wdata   (imem_wdata),
        .pc           (pc),
        .retire_valid (retire_valid),
        .retire_we    (retire_we),
        .retire_rd    (retire_rd),
        .retire_data  (retire_data),
        .halted       (halted)
    );

    always #2 clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("[ERROR] %s expected %h actual %h", name, expected, actual);
            $display("Finished with errors");
            $fatal(1);
        end
    endtask

    task automatic wait_for_retire();
        int n;
        n = 0;
        @(negedge clk);
        while (!retire_valid && n < retire_limit) begin
            @(negedge clk);
            n++;
        end
        if (!retire_valid) begin
            $display("no instruction retired within %0d cycles", retire_limit);
            $display("Finished with errors");
            $fatal(1);
        end
    endtask

    function automatic logic [31:0] encode_inst(input logic [3:0] op, input logic [3:0] rd,
                                                input logic [3:0] rs1, input logic [3:0] rs2,
                                                input logic [15:0] imm);
        return {op, rd, rs1, rs2, imm};
    endfunction

    function automatic logic [31:0] alu_inst(input logic [3:0] rd, input logic [3:0] rs1,
                                             input logic [3:0] rs2, input logic [2:0] func);
        return encode_inst(op_alu, rd, rs1, rs2, {13'd0, func});
    endfunction

    task automatic emit(input logic [31:0] word);
        prog[prog_len[7:0]] = word;
        prog_len++;
    endtask

    task automatic build_program();
        logic [31:0] r1;
        logic [31:0] r2;
        logic [31:0] r3;
        int          top;
        r1 = $random(seed);
        r2 = $random(seed);
        r3 = $random(seed);
        // random operands, a shift amount above 15 and a negative value
        emit(encode_inst(op_li, 4'd1, 4'd0, 4'd0, r1[15:0]));
        emit(encode_inst(op_li, 4'd2, 4'd0, 4'd0, r2[15:0]));
        emit(encode_inst(op_li, 4'd3, 4'd0, 4'd0, {11'd0, 1'b1, r3[3:0]}));
        emit(encode_inst(op_li, 4'd4, 4'd0, 4'd0, 16'hfffb));
        // all eight functions into r5..r12 with shifts taking r3
        for (int f = 0; f < 8; f++) begin
            if (f == 5 || f == 6) begin
                emit(alu_inst(4'(f + 5), 4'd1, 4'd3, 3'(f)));
            end else begin
                emit(alu_inst(4'(f + 5), 4'd1, 4'd2, 3'(f)));
            end
        end
        // negative r4 against positive r3 in both orders
        emit(alu_inst(4'd13, 4'd4, 4'd3, alu_slt));
        emit(alu_inst(4'd14, 4'd3, 4'd4, alu_slt));
        // r0 as destination and then as source
        emit(alu_inst(4'd0, 4'd1, 4'd2, alu_add));
        emit(alu_inst(4'd15, 4'd0, 4'd1, alu_or));
        // stores then loads where 7 + 300 wraps to 51
        emit(encode_inst(op_li, 4'd5, 4'd0, 4'd0, 16'd7));
        emit(encode_inst(op_store, 4'd0, 4'd5, 4'd1, 16'd3));
        emit(encode_inst(op_store, 4'd0, 4'd0, 4'd2, 16'd200));
        emit(encode_inst(op_store, 4'd0, 4'd5, 4'd9, 16'd300));
        emit(encode_inst(op_load, 4'd6, 4'd5, 4'd0, 16'd3));
        emit(encode_inst(op_load, 4'd7, 4'd0, 4'd0, 16'd200));
        emit(encode_inst(op_load, 4'd8, 4'd0, 4'd0, 16'd51));
        // counted loops on bne and then on blt
        emit(encode_inst(op_li, 4'd1, 4'd0, 4'd0, 16'd0));
        emit(encode_inst(op_li, 4'd2, 4'd0, 4'd0, 16'd5));
        emit(encode_inst(op_li, 4'd3, 4'd0, 4'd0, 16'd1));
        top = prog_len;
        emit(alu_inst(4'd1, 4'd1, 4'd3, alu_add));
        emit(encode_inst(op_branch, {2'b00, bne}, 4'd1, 4'd2, top[15:0]));
        emit(encode_inst(op_li, 4'd1, 4'd0, 4'd0, 16'd0));
        top = prog_len;
        emit(alu_inst(4'd1, 4'd1, 4'd3, alu_add));
        emit(encode_inst(op_branch, {2'b00, blt}, 4'd1, 4'd2, top[15:0]));
        // r1 == r2 == 5 from here on
        emit(encode_inst(op_branch, {2'b00, beq}, 4'd1, 4'd2, 16'(prog_len + 2)));
        emit(encode_inst(op_li, 4'd9, 4'd0, 4'd0, 16'd1));
        emit(encode_inst(op_branch, {2'b00, beq}, 4'd1, 4'd0, 16'(prog_len + 2)));
        emit(encode_inst(op_branch, {2'b00, bge}, 4'd1, 4'd2, 16'(prog_len + 2)));
        emit(encode_inst(op_li, 4'd9, 4'd0, 4'd0, 16'd2));
        emit(encode_inst(op_branch, {2'b00, bge}, 4'd4, 4'd1, 16'(prog_len + 2)));
        // jump and link over two words
        emit(encode_inst(op_jump, 4'd15, 4'd0, 4'd0, 16'(prog_len + 3)));
        emit(encode_inst(op_li, 4'd10, 4'd0, 4'd0, 16'd3));
        emit(encode_inst(op_li, 4'd10, 4'd0, 4'd0, 16'd4));
        emit(alu_inst(4'd11, 4'd15, 4'd0, alu_add));
        emit(encode_inst(op_halt, 4'd0, 4'd0, 4'd0, 16'd0));
    endtask

    // instruction set reference that also updates the model state
    function automatic void model_step(input logic [31:0] ins, output logic [31:0] e_pc,
                                       output logic e_we, output logic [3:0] e_rd,
                                       output logic [31:0] e_data, output logic e_halt);
        logic [31:0] imm;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] addr;
        logic [31:0] next_pc;
        logic        take;
        imm     = {{16{ins[15]}}, ins[15:0]};
        a       = model_regs[ins[23:20]];
        b       = model_regs[ins[19:16]];
        addr    = a + imm;
        take    = 1'b0;
        e_pc    = model_pc;
        e_we    = 1'b0;
        e_rd    = ins[27:24];
        e_data  = '0;
        e_halt  = 1'b0;
        next_pc = model_pc + 32'd1;
        case (ins[31:28])
            op_alu: begin
                e_we = 1'b1;
                case (ins[2:0])
                    alu_add: e_data = a + b;
                    alu_sub: e_data = a - b;
                    alu_and: e_data = a & b;
                    alu_or:  e_data = a | b;
                    alu_xor: e_data = a ^ b;
                    alu_sll: e_data = a << b[4:0];
                    alu_srl: e_data = a >> b[4:0];
                    default: e_data = {31'd0, $signed(a) < $signed(b)};
                endcase
            end
            op_li: begin
                e_we   = 1'b1;
                e_data = imm;
            end
            op_load: begin
                e_we   = 1'b1;
                e_data = model_dmem[addr[7:0]];
            end
            op_store: begin
                model_dmem[addr[7:0]] = b;
            end
            op_branch: begin
                case (ins[25:24])
                    beq:     take = (a == b);
                    bne:     take = (a != b);
                    blt:     take = ($signed(a) < $signed(b));
                    default: take = ($signed(a) >= $signed(b));
                endcase
                if (take) begin
                    next_pc = imm;
                end
            end
            op_jump: begin
                e_we    = 1'b1;
                e_data  = model_pc + 32'd1;
                next_pc = imm;
            end
            default: begin
                e_halt = 1'b1;
            end
        endcase
        // r0 is never written
        if (e_rd == 4'd0) begin
            e_we = 1'b0;
        end
        if (e_we) begin
            model_regs[e_rd] = e_data;
        end
        model_pc = next_pc;
    endfunction

    // reset and program load
    initial begin
        clk        = 1'b0;
        rstn       = 1'b0;
        imem_we    = 1'b0;
        imem_addr  = '0;
        imem_wdata = '0;
        seed       = 32'h1bf7;
        prog_len   = 0;
        model_regs = '{default: '0};
        model_pc   = '0;
        build_program();
        // the load runs past the reset but stays far ahead of the fetch
        for (int i = 0; i < prog_len; i++) begin
            @(posedge clk);
            imem_we    <= 1'b1;
            imem_addr  <= i[7:0];
            imem_wdata <= prog[i[7:0]];
            if (i == reset_cycles - 1) begin
                rstn <= 1'b1;
            end
        end
        @(posedge clk);
        imem_we <= 1'b0;
    end

    // retire comparison
    initial begin
        logic [31:0] e_pc;
        logic        e_we;
        logic [3:0]  e_rd;
        logic [31:0] e_data;
        logic        e_halt;
        int          n;
        int          retired;
        string       tag;
        e_halt  = 1'b0;
        retired = 0;
        n       = 0;
        @(negedge clk);
        while (!rstn && n < 100) begin
            @(negedge clk);
            n++;
        end
        if (!rstn) begin
            $display("reset was never released");
            $display("Finished with errors");
            $fatal(1);
        end
        check_value("after reset retire_valid", 32'd0, {31'd0, retire_valid});
        check_value("after reset halted", 32'd0, {31'd0, halted});
        while (!e_halt && retired < max_retires) begin
            wait_for_retire();
            model_step(prog[model_pc[7:0]], e_pc, e_we, e_rd, e_data, e_halt);
            tag = $sformatf("retire %0d", retired);
            check_value({tag, " pc"}, e_pc, pc);
            check_value({tag, " retire_we"}, {31'd0, e_we}, {31'd0, retire_we});
            check_value({tag, " halted"}, 32'd0, {31'd0, halted});
            if (e_we) begin
                check_value({tag, " retire_rd"}, {28'd0, e_rd}, {28'd0, retire_rd});
                check_value({tag, " retire_data"}, e_data, retire_data);
            end
            retired++;
        end
        if (e_halt) begin
            n = 0;
            @(negedge clk);
            while (!halted && n < 10) begin
                @(negedge clk);
                n++;
            end
            check_value("halted after halt", 32'd1, {31'd0, halted});
            repeat (100) begin
                @(negedge clk);
                check_value("retire after halt", 32'd0, {31'd0, retire_valid});
            end
            $display("Finished with no errors");
            $finish;
        end else begin
            $display("the program did not reach halt within %0d retires", max_retires);
            $display("Finished with errors");
            $fatal(1);
        end
    end

endmodule

/* rtl/cpu_top.sv */
`timescale 1ns/1ps

module cpu_top #(
    parameter int imem_aw = 8,
    parameter int dmem_aw = 8
) (
    input  logic                       clk,
    input  logic                       rstn,
    input  logic                       imem_we,
    input  logic [imem_aw-1:0]         imem_addr,
    input  logic [cpu_pkg::word_w-1:0] imem_wdata,
    output logic [cpu_pkg::word_w-1:0] pc,
    output logic                       retire_valid,
    output logic                       retire_we,
    output logic [cpu_pkg::reg_aw-1:0] retire_rd,
    output logic [cpu_pkg::word_w-1:0] retire_data,
    output logic                       halted
);
    import cpu_pkg::*;

    logic               fetch_order;
    logic [imem_aw-1:0] fetch_pc;
    logic [word_w-1:0]  inst;
    logic               fetched;
    logic               mem_flag;
    logic               mem_write;
    logic [dmem_aw-1:0] mem_addr;
    logic [word_w-1:0]  mem_wdata;
    logic [word_w-1:0]  mem_rdata;
    logic               mem_accessed;

    cpu #(
        .imem_aw (imem_aw),
        .dmem_aw (dmem_aw)
    ) i_cpu (
        .clk          (clk),
        .rstn         (rstn),
        .fetch_order  (fetch_order),
        .fetch_pc     (fetch_pc),
        .inst         (inst),
        .fetched      (fetched),
        .mem_flag     (mem_flag),
        .mem_write    (mem_write),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .mem_rdata    (mem_rdata),
        .mem_accessed (mem_accessed),
        .pc           (pc),
        .retire_valid (retire_valid),
        .retire_we    (retire_we),
        .retire_rd    (retire_rd),
        .retire_data  (retire_data),
        .halted       (halted)
    );

    // instruction memory, loaded while the core sits in reset
    fetch #(
        .imem_aw (imem_aw)
    ) i_fetch (
        .clk         (clk),
        .rstn        (rstn),
        .fetch_order (fetch_order),
        .fetch_pc    (fetch_pc),
        .load_we     (imem_we),
        .load_addr   (imem_addr),
        .load_data   (imem_wdata),
        .inst        (inst),
        .fetched     (fetched)
    );

    memory #(
        .dmem_aw (dmem_aw)
    ) i_memory (
        .clk          (clk),
        .rstn         (rstn),
        .mem_flag     (mem_flag),
        .mem_write    (mem_write),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .mem_rdata    (mem_rdata),
        .mem_accessed (mem_accessed)
    );

endmodule

/* rtl/cpu.sv */
`timescale 1ns/1ps

module cpu #(
    parameter int imem_aw = 8,
    parameter int dmem_aw = 8
) (
    input  logic                       clk,
    input  logic                       rstn,
    output logic                       fetch_order,
    output logic [imem_aw-1:0]         fetch_pc,
    input  logic [cpu_pkg::word_w-1:0] inst,
    input  logic                       fetched,
    output logic                       mem_flag,
    output logic                       mem_write,
    output logic [dmem_aw-1:0]         mem_addr,
    output logic [cpu_pkg::word_w-1:0] mem_wdata,
    input  logic [cpu_pkg::word_w-1:0] mem_rdata,
    input  logic                       mem_accessed,
    output logic [cpu_pkg::word_w-1:0] pc,
    output logic                       retire_valid,
    output logic                       retire_we,
    output logic [cpu_pkg::reg_aw-1:0] retire_rd,
    output logic [cpu_pkg::word_w-1:0] retire_data,
    output logic                       halted
);
    import cpu_pkg::*;

    typedef enum logic [2:0] {
        st_fetch,
        st_fetch_wait,
        st_decode,
        st_execute,
        st_execute_wait,
        st_write,
        st_halted
    } state_t;

    state_t state;

    // fetch to decode
    logic [word_w-1:0] inst_fd;

    // decoder outputs
    logic [reg_aw-1:0] dec_rs1_addr;
    logic [reg_aw-1:0] dec_rs2_addr;
    logic [reg_aw-1:0] dec_rd_addr;
    opcode_t           dec_opcode;
    alu_func_t         dec_func;
    branch_cond_t      dec_cond;
    logic [word_w-1:0] dec_imm;
    logic              dec_alu;
    logic              dec_li;
    logic              dec_load;
    logic              dec_store;
    logic              dec_branch;
    logic              dec_jump;
    logic              dec_halt;
    logic [word_w-1:0] rs1_data;
    logic [word_w-1:0] rs2_data;

    // decode to execute
    logic              is_alu_de;
    logic              is_li_de;
    logic              is_load_de;
    logic              is_store_de;
    logic              is_branch_de;
    logic              is_jump_de;
    logic              is_halt_de;
    logic              writes_de;
    logic [reg_aw-1:0] rd_de;
    alu_func_t         func_de;
    branch_cond_t      cond_de;
    logic [word_w-1:0] imm_de;
    logic [word_w-1:0] rs1_de;
    logic [word_w-1:0] rs2_de;

    // execute to write
    logic              wb_we;
    logic [reg_aw-1:0] wb_rd;
    logic [word_w-1:0] wb_data;
    logic [word_w-1:0] next_pc;

    logic [word_w-1:0] alu_result;
    logic              taken;
    logic [word_w-1:0] pc_inc;
    logic [word_w-1:0] eff_addr;
    logic              reg_we;

    regs i_regs (
        .clk      (clk),
        .rstn     (rstn),
        .we       (reg_we),
        .rd_addr  (wb_rd),
        .rd_data  (wb_data),
        .rs1_addr (dec_rs1_addr),
        .rs2_addr (dec_rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    decode i_decode (
        .inst      (inst_fd),
        .rs1_addr  (dec_rs1_addr),
        .rs2_addr  (dec_rs2_addr),
        .rd_addr   (dec_rd_addr),
        .opcode    (dec_opcode),
        .alu_func  (dec_func),
        .cond      (dec_cond),
        .imm       (dec_imm),
        .is_alu    (dec_alu),
        .is_li     (dec_li),
        .is_load   (dec_load),
        .is_store  (dec_store),
        .is_branch (dec_branch),
        .is_jump   (dec_jump),
        .is_halt   (dec_halt)
    );

    alu i_alu (
        .alu_func (func_de),
        .cond     (cond_de),
        .a        (rs1_de),
        .b        (rs2_de),
        .result   (alu_result),
        .taken    (taken)
    );

    assign pc_inc   = pc + word_w'(1);
    assign eff_addr = rs1_de + imm_de;

    // memory orders are issued in the state itself
    assign fetch_order = (state == st_fetch);
    assign fetch_pc    = pc[imem_aw-1:0];
    assign mem_flag    = (state == st_execute) && (is_load_de || is_store_de);
    assign mem_write   = is_store_de;
    assign mem_addr    = eff_addr[dmem_aw-1:0];
    assign mem_wdata   = rs2_de;

    assign reg_we       = (state == st_write) && wb_we;
    assign retire_valid = (state == st_write);
    assign retire_we    = wb_we;
    assign retire_rd    = wb_rd;
    assign retire_data  = wb_data;
    assign halted       = (state == st_halted);

    // sequencing and pc
    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= st_fetch;
            pc    <= '0;
            wb_we <= 1'b0;
        end else begin
            case (state)
                st_fetch: begin
                    state <= st_fetch_wait;
                end
                st_fetch_wait: begin
                    if (fetched) begin
                        state <= st_decode;
                    end
                end
                st_decode: begin
                    state <= st_execute;
                end
                st_execute: begin
                    // r0 destination never counts as a write
                    wb_we <= writes_de && (rd_de != '0);
                    if (is_load_de || is_store_de) begin
                        state <= st_execute_wait;
                    end else begin
                        state <= st_write;
                    end
                end
                st_execute_wait: begin
                    if (mem_accessed) begin
                        state <= st_write;
                    end
                end
                st_write: begin
                    pc    <= next_pc;
                    state <= is_halt_de ? st_halted : st_fetch;
                end
                default: begin
                    state <= st_halted;
                end
            endcase
        end
    end

    // stage registers
    always_ff @(posedge clk) begin
        case (state)
            st_fetch_wait: begin
                if (fetched) begin
                    inst_fd <= inst;
                end
            end
            st_decode: begin
                is_alu_de    <= dec_alu;
                is_li_de     <= dec_li;
                is_load_de   <= dec_load;
                is_store_de  <= dec_store;
                is_branch_de <= dec_branch;
                is_jump_de   <= dec_jump;
                is_halt_de   <= dec_halt;
                writes_de    <= dec_opcode inside {op_alu, op_li, op_load, op_jump};
                rd_de        <= dec_rd_addr;
                func_de      <= dec_func;
                cond_de      <= dec_cond;
                imm_de       <= dec_imm;
                rs1_de       <= rs1_data;
                rs2_de       <= rs2_data;
            end
            st_execute: begin
                wb_rd   <= rd_de;
                wb_data <= '0;
                next_pc <= pc_inc;
                if (is_alu_de) begin
                    wb_data <= alu_result;
                end else if (is_li_de) begin
                    wb_data <= imm_de;
                end else if (is_jump_de) begin
                    // link then go to the target
                    wb_data <= pc_inc;
                    next_pc <= imm_de;
                end else if (is_branch_de && taken) begin
                    next_pc <= imm_de;
                end
            end
            st_execute_wait: begin
                if (mem_accessed && is_load_de) begin
                    wb_data <= mem_rdata;
                end
            end
            default: begin
            end
        endcase
    end

endmodule

/* rtl/memory.sv */
`timescale 1ns/1ps

module memory #(
    parameter int dmem_aw = 8
) (
    input  logic                       clk,
    input  logic                       rstn,
    input  logic                       mem_flag,
    input  logic                       mem_write,
    input  logic [dmem_aw-1:0]         mem_addr,
    input  logic [cpu_pkg::word_w-1:0] mem_wdata,
    output logic [cpu_pkg::word_w-1:0] mem_rdata,
    output logic                       mem_accessed
);
    import cpu_pkg::*;

    logic [word_w-1:0]  dmem [2**dmem_aw];
    logic               flag_q;
    logic               write_q;
    logic [dmem_aw-1:0] addr_q;
    logic [word_w-1:0]  wdata_q;

    // request pipeline strobes
    always_ff @(posedge clk) begin
        if (!rstn) begin
            flag_q       <= 1'b0;
            mem_accessed <= 1'b0;
        end else begin
            flag_q       <= mem_flag;
            mem_accessed <= flag_q;
        end
    end

    // first stage latches the request, second stage does the access
    always_ff @(posedge clk) begin
        if (mem_flag) begin
            write_q <= mem_write;
            addr_q  <= mem_addr;
            wdata_q <= mem_wdata;
        end
        if (flag_q) begin
            if (write_q) begin
                dmem[addr_q] <= wdata_q;
            end
            mem_rdata <= dmem[addr_q];
        end
    end

endmodule

/* rtl/alu.sv */
`timescale 1ns/1ps

module alu (
    input  cpu_pkg::alu_func_t         alu_func,
    input  cpu_pkg::branch_cond_t      cond,
    input  logic [cpu_pkg::word_w-1:0] a,
    input  logic [cpu_pkg::word_w-1:0] b,
    output logic [cpu_pkg::word_w-1:0] result,
    output logic                       taken
);
    import cpu_pkg::*;

    logic lt_signed;

    assign lt_signed = ($signed(a) < $signed(b));

    always_comb begin
        case (alu_func)
            alu_add: result = a + b;
            alu_sub: result = a - b;
            alu_and: result = a & b;
            alu_or:  result = a | b;
            alu_xor: result = a ^ b;
            // shift amount from the low five bits
            alu_sll: result = a << b[shamt_w-1:0];
            alu_srl: result = a >> b[shamt_w-1:0];
            alu_slt: result = {{(word_w-1){1'b0}}, lt_signed};
            default: result = '0;
        endcase
    end

    // branch decision, signed compares for blt and bge
    always_comb begin
        case (cond)
            beq:     taken = (a == b);
            bne:     taken = (a != b);
            blt:     taken = lt_signed;
            default: taken = !lt_signed;
        endcase
    end

endmodule

/* rtl/decode.sv */
`timescale 1ns/1ps

module decode (
    input  logic [cpu_pkg::word_w-1:0] inst,
    output logic [cpu_pkg::reg_aw-1:0] rs1_addr,
    output logic [cpu_pkg::reg_aw-1:0] rs2_addr,
    output logic [cpu_pkg::reg_aw-1:0] rd_addr,
    output cpu_pkg::opcode_t           opcode,
    output cpu_pkg::alu_func_t         alu_func,
    output cpu_pkg::branch_cond_t      cond,
    output logic [cpu_pkg::word_w-1:0] imm,
    output logic                       is_alu,
    output logic                       is_li,
    output logic                       is_load,
    output logic                       is_store,
    output logic                       is_branch,
    output logic                       is_jump,
    output logic                       is_halt
);
    import cpu_pkg::*;

    opcode_t raw_op;

    assign raw_op = opcode_t'(inst[op_msb:op_lsb]);

    // anything outside the defined set stops the core
    always_comb begin
        case (raw_op)
            op_alu,
            op_li,
            op_load,
            op_store,
            op_branch,
            op_jump: opcode = raw_op;
            default: opcode = op_halt;
        endcase
    end

    assign is_alu    = (opcode == op_alu);
    assign is_li     = (opcode == op_li);
    assign is_load   = (opcode == op_load);
    assign is_store  = (opcode == op_store);
    assign is_branch = (opcode == op_branch);
    assign is_jump   = (opcode == op_jump);
    assign is_halt   = (opcode == op_halt);

    // register fields
    assign rd_addr  = inst[rd_msb:rd_lsb];
    assign rs1_addr = inst[rs1_msb:rs1_lsb];
    assign rs2_addr = inst[rs2_msb:rs2_lsb];

    // alu function sits in the immediate, branch condition in rd
    assign alu_func = alu_func_t'(inst[func_w-1:0]);
    assign cond     = branch_cond_t'(inst[rd_lsb+cond_w-1:rd_lsb]);

    assign imm = {{(word_w-imm_w){inst[imm_msb]}}, inst[imm_msb:0]};

endmodule

/* rtl/fetch.sv */
`timescale 1ns/1ps

module fetch #(
    parameter int imem_aw = 8
) (
    input  logic                       clk,
    input  logic                       rstn,
    input  logic                       fetch_order,
    input  logic [imem_aw-1:0]         fetch_pc,
    input  logic                       load_we,
    input  logic [imem_aw-1:0]         load_addr,
    input  logic [cpu_pkg::word_w-1:0] load_data,
    output logic [cpu_pkg::word_w-1:0] inst,
    output logic                       fetched
);
    import cpu_pkg::*;

    logic [word_w-1:0]  imem [2**imem_aw];
    logic               order_q;
    logic [imem_aw-1:0] addr_q;

    // program load port
    always_ff @(posedge clk) begin
        if (load_we) begin
            imem[load_addr] <= load_data;
        end
    end

    // two-stage delay line for the order
    always_ff @(posedge clk) begin
        if (!rstn) begin
            order_q <= 1'b0;
            fetched <= 1'b0;
        end else begin
            order_q <= fetch_order;
            fetched <= order_q;
        end
    end

    // address taken on the order, word read in the second stage
    always_ff @(posedge clk) begin
        if (fetch_order) begin
            addr_q <= fetch_pc;
        end
        if (order_q) begin
            inst <= imem[addr_q];
        end
    end

endmodule

/* rtl/regs.sv */
`timescale 1ns/1ps

module regs (
    input  logic                       clk,
    input  logic                       rstn,
    input  logic                       we,
    input  logic [cpu_pkg::reg_aw-1:0] rd_addr,
    input  logic [cpu_pkg::word_w-1:0] rd_data,
    input  logic [cpu_pkg::reg_aw-1:0] rs1_addr,
    input  logic [cpu_pkg::reg_aw-1:0] rs2_addr,
    output logic [cpu_pkg::word_w-1:0] rs1_data,
    output logic [cpu_pkg::word_w-1:0] rs2_data
);
    import cpu_pkg::*;

    logic [word_w-1:0] rf [num_reg];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < num_reg; i++) begin
                rf[i] <= '0;
            end
        end else if (we && (rd_addr != '0)) begin
            // r0 is never written
            rf[rd_addr] <= rd_data;
        end
    end

    // two asynchronous read ports, r0 reads as zero
    assign rs1_data = (rs1_addr == '0) ? '0 : rf[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : rf[rs2_addr];

endmodule

/* rtl/cpu_pkg.sv */
package cpu_pkg;

    // datapath widths
    localparam int word_w  = 32;
    localparam int reg_aw  = 4;
    localparam int num_reg = 16;
    localparam int op_w    = 4;
    localparam int func_w  = 3;
    localparam int cond_w  = 2;
    localparam int imm_w   = 16;
    localparam int shamt_w = 5;

    // instruction field positions
    localparam int op_msb  = 31;
    localparam int op_lsb  = 28;
    localparam int rd_msb  = 27;
    localparam int rd_lsb  = 24;
    localparam int rs1_msb = 23;
    localparam int rs1_lsb = 20;
    localparam int rs2_msb = 19;
    localparam int rs2_lsb = 16;
    localparam int imm_msb = 15;

    typedef enum logic [op_w-1:0] {
        op_alu    = 4'd0,
        op_li     = 4'd1,
        op_load   = 4'd2,
        op_store  = 4'd3,
        op_branch = 4'd4,
        op_jump   = 4'd5,
        op_halt   = 4'd6
    } opcode_t;

    // held in the low immediate bits of op_alu
    typedef enum logic [func_w-1:0] {
        alu_add = 3'd0,
        alu_sub = 3'd1,
        alu_and = 3'd2,
        alu_or  = 3'd3,
        alu_xor = 3'd4,
        alu_sll = 3'd5,
        alu_srl = 3'd6,
        alu_slt = 3'd7
    } alu_func_t;

    // held in the low rd bits of op_branch
    typedef enum logic [cond_w-1:0] {
        beq = 2'd0,
        bne = 2'd1,
        blt = 2'd2,
        bge = 2'd3
    } branch_cond_t;

endpackage
